/* Makefile */
TOP := tb_cache

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* design/backing_mem.sv */
// fixed latency backing memory
`timescale 1ns/1ns

module backing_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  cache_pkg::mem_req_t mem_req_i,
  output cache_pkg::mem_rsp_t mem_rsp_o
);
  import cache_pkg::*;

  localparam int unsigned CNT_WIDTH = $clog2(MEM_LATENCY + 1);

  logic [WORD_WIDTH-1:0]   mem_q [2**ADDR_WIDTH];
  logic [CNT_WIDTH-1:0]    cnt_q;
  logic                    ack_q;
  line_t                   rline_q;
  logic                    fire;
  // line aligned upper address bits
  logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr;

  assign mem_rsp_o = '{ack: ack_q, rline: rline_q};

  assign line_addr = mem_req_i.addr[ADDR_WIDTH-1:OFFSET_WIDTH];
  // last waiting cycle, ack follows at the next edge
  assign fire = mem_req_i.valid && !ack_q &&
                (cnt_q == CNT_WIDTH'(MEM_LATENCY - 1));

  // --------------------
  // latency and storage
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
      for (int unsigned i = 0; i < 2**ADDR_WIDTH; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      ack_q <= fire;
      if (ack_q) begin
        cnt_q <= '0;
      end else if (mem_req_i.valid) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // word write under the byte enables
      if (fire && mem_req_i.we) begin
        for (int unsigned b = 0; b < BE_WIDTH; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[mem_req_i.addr][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // whole aligned line for every access
  always_ff @(posedge clk_i) begin
    if (fire) begin
      for (int unsigned w = 0; w < WORDS_PER_LINE; w++) begin
        rline_q[w] <= mem_q[{line_addr, OFFSET_WIDTH'(w)}];
      end
    end
  end

  // the controller must hold its request until the ack
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i.valid && !mem_rsp_o.ack) |=> $stable(mem_req_i));

endmodule

/* design/cache_array.sv */
// single port array bank
`timescale 1ns/1ns

module cache_array #(
  parameter type entry_t = cache_pkg::line_t
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              en_i,
  input  logic                              we_i,
  input  logic [cache_pkg::INDEX_WIDTH-1:0] index_i,
  input  entry_t                            wdata_i,
  output entry_t                            rdata_o
);
  import cache_pkg::*;

  // one entry per set
  entry_t mem_q [NUM_SETS];

  // --------------------
  // storage and read port
  // --------------------
  // cleared on reset so every tag starts invalid
  // read data is registered and held while en_i is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NUM_SETS; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (en_i) begin
      if (we_i) begin
        mem_q[index_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[index_i];
      end
    end
  end

  // a way select from the controller must come with the shared enable
  we_needs_en_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> en_i);

endmodule

/* design/cache_ctrl.sv */
// cache hit, miss and store controller
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         start_i,
  input  cache_pkg::pend_req_t                         pend_i,
  input  cache_pkg::tag_entry_t [cache_pkg::NUM_WAYS-1:0] tag_rd_i,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]   line_rd_i,
  output cache_pkg::arr_req_t                          arr_wr_o,
  output cache_pkg::tag_entry_t                        tag_wr_o,
  output cache_pkg::line_t                             line_wr_o,
  output cache_pkg::mem_req_t                          mem_req_o,
  input  cache_pkg::mem_rsp_t                          mem_rsp_i,
  output logic                                         store_gnt_o,
  output logic                                         done_o,
  output cache_pkg::core_rsp_t                         rsp_o
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_REFILL_WAIT,
    S_STORE_WAIT
  } state_e;

  state_e                state_d, state_q;
  logic [NUM_WAYS-1:0]   hit_vec;
  logic [NUM_WAYS-1:0]   victim_vec;
  line_t                 hit_line;
  line_t                 merged_line;
  logic [WORD_WIDTH-1:0] hit_word;
  logic [WORD_WIDTH-1:0] merged_word;
  logic [WORD_WIDTH-1:0] fill_word_q;
  logic                  mem_ack_q;
  // one round-robin bit per set picks the next victim way
  logic [NUM_SETS-1:0]   rr_q;
  logic                  refill_en;

  // --------------------
  // way select
  // --------------------
  always_comb begin
    hit_line = '0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = tag_rd_i[w].valid && (tag_rd_i[w].tag == pend_i.tag);
      if (hit_vec[w]) begin
        hit_line = hit_line | line_rd_i[w];
      end
    end
    hit_word = hit_line[pend_i.offset];
  end

  // store bytes merged over the hit word
  always_comb begin
    merged_word = hit_word;
    for (int unsigned b = 0; b < BE_WIDTH; b++) begin
      if (pend_i.be[b]) begin
        merged_word[8*b +: 8] = pend_i.wdata[8*b +: 8];
      end
    end
    merged_line = hit_line;
    merged_line[pend_i.offset] = merged_word;
  end

  // victim way from the set's round-robin bit
  always_comb begin
    victim_vec = '0;
    victim_vec[rr_q[pend_i.index]] = 1'b1;
  end

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_d   = state_q;
    refill_en = 1'b0;
    arr_wr_o  = '0;
    tag_wr_o.valid = 1'b1;
    tag_wr_o.tag   = pend_i.tag;
    line_wr_o = mem_rsp_i.rline;
    // memory fields follow the pending request, only valid is gated
    mem_req_o.valid = 1'b0;
    mem_req_o.we    = pend_i.we;
    mem_req_o.addr  = {pend_i.tag, pend_i.index, pend_i.offset};
    mem_req_o.be    = pend_i.be;
    mem_req_o.wdata = pend_i.wdata;
    store_gnt_o  = 1'b0;
    done_o       = 1'b0;
    rsp_o.rvalid = 1'b0;
    rsp_o.rid    = pend_i.id;
    rsp_o.rdata  = '0;

    case (state_q)
      S_IDLE: begin
        if (start_i) begin
          state_d = S_LOOKUP;
          // write-through does not wait for the tag compare
          mem_req_o.valid = pend_i.we;
        end
      end
      S_LOOKUP: begin
        if (pend_i.we) begin
          mem_req_o.valid = 1'b1;
          state_d = S_STORE_WAIT;
          // store hit updates the line in place
          if (|hit_vec) begin
            arr_wr_o.en     = 1'b1;
            arr_wr_o.we_way = hit_vec;
            arr_wr_o.index  = pend_i.index;
            line_wr_o       = merged_line;
          end
        end else if (|hit_vec) begin
          rsp_o.rvalid = 1'b1;
          rsp_o.rdata  = hit_word;
          done_o  = 1'b1;
          state_d = S_IDLE;
        end else begin
          mem_req_o.valid = 1'b1;
          state_d = S_REFILL_WAIT;
        end
      end
      S_REFILL_WAIT: begin
        if (mem_ack_q) begin
          rsp_o.rvalid = 1'b1;
          rsp_o.rdata  = fill_word_q;
          done_o  = 1'b1;
          state_d = S_IDLE;
        end else begin
          mem_req_o.valid = 1'b1;
          // line and tag go into the victim on the ack cycle
          if (mem_rsp_i.ack) begin
            refill_en       = 1'b1;
            arr_wr_o.en     = 1'b1;
            arr_wr_o.we_way = victim_vec;
            arr_wr_o.index  = pend_i.index;
          end
        end
      end
      S_STORE_WAIT: begin
        if (mem_ack_q) begin
          store_gnt_o = 1'b1;
          done_o  = 1'b1;
          state_d = S_IDLE;
        end else begin
          mem_req_o.valid = 1'b1;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      mem_ack_q <= 1'b0;
      rr_q      <= '0;
    end else begin
      state_q   <= state_d;
      mem_ack_q <= mem_rsp_i.ack;
      if (refill_en) begin
        rr_q[pend_i.index] <= ~rr_q[pend_i.index];
      end
    end
  end

  // refill word returned one cycle after ack
  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.ack) begin
      fill_word_q <= mem_rsp_i.rline[pend_i.offset];
    end
  end

  // a line lives in one way only
  hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == S_LOOKUP) |-> $onehot0(hit_vec));

  // responses only ever answer loads
  rvalid_load_only_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.rvalid |-> !pend_i.we);

endmodule

/* design/cache_pkg.sv */
// data cache shared types
// geometry and bus structs
package cache_pkg;

  // --------------------
  // geometry
  // --------------------
  localparam int unsigned WORD_WIDTH     = 64;
  localparam int unsigned BE_WIDTH       = 8;
  // word address, not byte address
  localparam int unsigned ADDR_WIDTH     = 10;
  localparam int unsigned WORDS_PER_LINE = 2;
  localparam int unsigned OFFSET_WIDTH   = 1;
  localparam int unsigned INDEX_WIDTH    = 4;
  localparam int unsigned TAG_WIDTH      = 5;
  localparam int unsigned NUM_SETS       = 16;
  localparam int unsigned NUM_WAYS       = 2;
  // cycles from valid rising to ack
  localparam int unsigned MEM_LATENCY    = 4;
  localparam int unsigned ID_WIDTH       = 4;

  // --------------------
  // core side
  // --------------------
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BE_WIDTH-1:0]   be;
    logic [WORD_WIDTH-1:0] wdata;
    logic [ID_WIDTH-1:0]   id;
  } core_req_t;

  typedef struct packed {
    logic                  rvalid;
    logic [ID_WIDTH-1:0]   rid;
    logic [WORD_WIDTH-1:0] rdata;
  } core_rsp_t;

  // --------------------
  // arrays
  // --------------------
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  // word 0 sits in the low half
  typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;

  // shared by the front read and the controller write
  typedef struct packed {
    logic                   en;
    logic [NUM_WAYS-1:0]    we_way;
    logic [INDEX_WIDTH-1:0] index;
  } arr_req_t;

  // request as captured by the front end
  typedef struct packed {
    logic                    we;
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [BE_WIDTH-1:0]     be;
    logic [WORD_WIDTH-1:0]   wdata;
    logic [ID_WIDTH-1:0]     id;
  } pend_req_t;

  // --------------------
  // backing memory
  // --------------------
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BE_WIDTH-1:0]   be;
    logic [WORD_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ack;
    line_t rline;
  } mem_rsp_t;

endpackage

/* design/cache_top.sv */
// two way write-through data cache
`timescale 1ns/1ns

module cache_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cache_pkg::core_req_t req_i,
  output logic                 gnt_o,
  output cache_pkg::core_rsp_t rsp_o,
  output logic                 busy_o
);
  import cache_pkg::*;

  logic                      load_gnt;
  logic                      store_gnt;
  logic                      start;
  logic                      done;
  arr_req_t                  arr_rd;
  arr_req_t                  arr_wr;
  arr_req_t                  arr_q;
  pend_req_t                 pend;
  tag_entry_t [NUM_WAYS-1:0] tag_rd;
  line_t [NUM_WAYS-1:0]      line_rd;
  tag_entry_t                tag_wr;
  line_t                     line_wr;
  mem_req_t                  mem_req;
  mem_rsp_t                  mem_rsp;

  // read and write never overlap, each side is zero when idle
  assign arr_q = arr_rd | arr_wr;
  assign gnt_o = load_gnt | store_gnt;

  req_front u_front (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .done_i   (done),
    .gnt_o    (load_gnt),
    .arr_rd_o (arr_rd),
    .pend_o   (pend),
    .start_o  (start),
    .busy_o   (busy_o)
  );

  // tag and line bank per way
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_array #(.entry_t(tag_entry_t)) u_tag (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (arr_q.en),
      .we_i    (arr_q.we_way[w]),
      .index_i (arr_q.index),
      .wdata_i (tag_wr),
      .rdata_o (tag_rd[w])
    );
    cache_array #(.entry_t(line_t)) u_line (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (arr_q.en),
      .we_i    (arr_q.we_way[w]),
      .index_i (arr_q.index),
      .wdata_i (line_wr),
      .rdata_o (line_rd[w])
    );
  end

  cache_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .pend_i      (pend),
    .tag_rd_i    (tag_rd),
    .line_rd_i   (line_rd),
    .arr_wr_o    (arr_wr),
    .tag_wr_o    (tag_wr),
    .line_wr_o   (line_wr),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .store_gnt_o (store_gnt),
    .done_o      (done),
    .rsp_o       (rsp_o)
  );

  backing_mem u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

endmodule

/* design/req_front.sv */
// cache request front end
`timescale 1ns/1ns

module req_front (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cache_pkg::core_req_t req_i,
  input  logic                 done_i,
  output logic                 gnt_o,
  output cache_pkg::arr_req_t  arr_rd_o,
  output cache_pkg::pend_req_t pend_o,
  output logic                 start_o,
  output logic                 busy_o
);
  import cache_pkg::*;

  logic                    busy_q;
  logic                    accept;
  logic [TAG_WIDTH-1:0]    req_tag;
  logic [INDEX_WIDTH-1:0]  req_index;
  logic [OFFSET_WIDTH-1:0] req_offset;

  // word address split
  assign req_tag    = req_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_index  = req_i.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign req_offset = req_i.addr[OFFSET_WIDTH-1:0];

  // take a request whenever nothing is in flight
  assign accept = req_i.req && !busy_q;
  // loads are granted on acceptance, stores later by the controller
  assign gnt_o  = accept && !req_i.we;
  assign busy_o = busy_q || accept;

  // read both arrays at the request index in the accept cycle
  // all zero otherwise so the top can OR in the controller write
  always_comb begin
    arr_rd_o = '0;
    if (accept) begin
      arr_rd_o.en    = 1'b1;
      arr_rd_o.index = req_index;
    end
  end

  // --------------------
  // control state
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_o <= 1'b0;
    end else begin
      start_o <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // captured request, held stable until done
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pend_o.we     <= req_i.we;
      pend_o.tag    <= req_tag;
      pend_o.index  <= req_index;
      pend_o.offset <= req_offset;
      pend_o.be     <= req_i.be;
      pend_o.wdata  <= req_i.wdata;
      pend_o.id     <= req_i.id;
    end
  end

  // done only closes a request that has already started
  single_pending_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> (busy_q && !start_o));

endmodule

/* sim.f */
+incdir+verif
design/cache_pkg.sv
design/cache_array.sv
design/req_front.sv
design/cache_ctrl.sv
design/backing_mem.sv
design/cache_top.sv
verif/tb_cache.sv

/* verif/tb_util.svh */
// cache testbench helpers
// random source, compare and reference memory
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// --------------------
// random source
// --------------------
// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// n bits, one lfsr step per bit, first bit taken ends up as the msb
function automatic logic [63:0] rand_bits(input int unsigned n);
  logic [63:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    v      = {v[62:0], lfsr_q[15]};
    lfsr_q = lfsr_next(lfsr_q);
  end
  return v;
endfunction

// --------------------
// compare
// --------------------
task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    mism_cnt++;
    $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
  end
endtask

// --------------------
// reference memory
// --------------------
// flat word memory, the cache is write-through so memory is always current
function automatic logic [WORD_WIDTH-1:0] ref_load(input logic [ADDR_WIDTH-1:0] addr);
  return ref_mem[addr];
endfunction

// byte-masked store into the reference word
function automatic void ref_store(input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [BE_WIDTH-1:0]   be,
                                  input logic [WORD_WIDTH-1:0] wdata);
  for (int unsigned b = 0; b < BE_WIDTH; b++) begin
    if (be[b]) begin
      ref_mem[addr][8*b +: 8] = wdata[8*b +: 8];
    end
  end
endfunction

`endif

/* verif/tb_cache.sv */
// data cache testbench
`timescale 1ns/1ns

module tb_cache;
  import cache_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_RAND     = 320;
  // directed requests: 4 + 4 + 9 + 6 + 6
  localparam int NUM_REQS     = 29 + NUM_RAND;
  localparam int WDOG_CYCLES  = RESET_CYCLES + NUM_REQS * (MEM_LATENCY + 10);
  localparam int WAIT_LIMIT   = 50;

  // one outstanding load as seen at its grant
  typedef struct packed {
    logic [WORD_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]   id;
    int                    gnt;
    int                    lat;
  } exp_t;

  logic                  clk;
  logic                  rst_n;
  core_req_t             req;
  logic                  gnt;
  core_rsp_t             rsp;
  logic                  busy;
  logic [15:0]           lfsr_q = 16'd34145;
  logic [WORD_WIDTH-1:0] ref_mem [2**ADDR_WIDTH];
  logic [ID_WIDTH-1:0]   next_id;
  int                    mism_cnt = 0;
  int                    fail_cnt = 0;
  int                    cycle_cnt = 0;
  exp_t                  exp_q [$];

  `include "tb_util.svh"

  cache_top dut0 (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .req_i  (req),
    .gnt_o  (gnt),
    .rsp_o  (rsp),
    .busy_o (busy)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // edge count, readers at an edge see the count before it
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------
  // request driver
  // --------------------
  // waits for idle, drives on the falling edge, records the expectation
  task automatic issue(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                       input logic [BE_WIDTH-1:0] be, input logic [WORD_WIDTH-1:0] wdata,
                       input int lat);
    core_req_t r;
    exp_t      e;
    int        acc;
    int        n;
    n = 0;
    @(posedge clk);
    while (busy && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (busy) begin
      fail_cnt++;
      $display("cache still busy before the request to %h", addr);
    end
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    r.id    = next_id;
    @(negedge clk);
    req = r;
    // idle cache, so this edge accepts
    @(posedge clk);
    acc = cycle_cnt;
    if (!we) begin
      check_val("gnt_o", 64'(gnt), 64'd1);
      e.data = ref_load(addr);
      e.id   = next_id;
      e.gnt  = acc;
      e.lat  = lat;
      exp_q.push_back(e);
    end else begin
      n = 0;
      while (!gnt && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
      end
      if (gnt) begin
        check_val("store gnt latency", 64'(cycle_cnt - acc), 64'(MEM_LATENCY + 2));
        ref_store(addr, be, wdata);
      end else begin
        fail_cnt++;
        $display("store to %h was never granted", addr);
      end
    end
    @(negedge clk);
    req.req = 1'b0;
    next_id = next_id + 1'b1;
  endtask

  // --------------------
  // response checker
  // --------------------
  always @(posedge clk) begin : rsp_check
    exp_t e;
    if (rst_n && rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("response with id %h arrived with no load outstanding", rsp.rid);
      end else begin
        e = exp_q.pop_front();
        check_val("rsp_o.rdata", rsp.rdata, e.data);
        check_val("rsp_o.rid", 64'(rsp.rid), 64'(e.id));
        // negative latency means timing not checked
        if (e.lat >= 0) begin
          check_val("rvalid latency", 64'(cycle_cnt - e.gnt), 64'(e.lat));
        end
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  initial begin : stimulus
    logic [ADDR_WIDTH-1:0] a;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [WORD_WIDTH-1:0] wd;
    int                    n;
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      ref_mem[i] = '0;
    end
    next_id = '0;
    req     = '0;
    rst_n   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet outputs before the first request
    repeat (2) begin
      @(posedge clk);
      check_val("busy_o", 64'(busy), 64'd0);
      check_val("rsp_o.rvalid", 64'(rsp.rvalid), 64'd0);
      check_val("gnt_o", 64'(gnt), 64'd0);
    end

    // untouched words read back as zero
    issue(1'b0, 10'h000, '0, '0, -1);
    issue(1'b0, 10'h001, '0, '0, -1);
    issue(1'b0, 10'h155, '0, '0, -1);
    issue(1'b0, 10'h3ff, '0, '0, -1);

    // store miss, load miss, store hit, load hit on one word
    a = 10'h020;
    repeat (2) begin
      be = BE_WIDTH'(rand_bits(BE_WIDTH));
      wd = rand_bits(WORD_WIDTH);
      issue(1'b1, a, be, wd, -1);
      issue(1'b0, a, '0, '0, -1);
    end

    // distinct nonzero words so a wrong line or way cannot read back right
    // stores do not allocate, so the loads below still miss first
    issue(1'b1, 10'h046, '1, rand_bits(WORD_WIDTH), -1);
    issue(1'b1, 10'h047, '1, rand_bits(WORD_WIDTH), -1);
    issue(1'b1, 10'h0a8, '1, rand_bits(WORD_WIDTH), -1);
    issue(1'b1, 10'h0a9, '1, rand_bits(WORD_WIDTH), -1);
    issue(1'b1, 10'h31c, '1, rand_bits(WORD_WIDTH), -1);
    issue(1'b1, 10'h31d, '1, rand_bits(WORD_WIDTH), -1);
    for (int t = 1; t <= 3; t++) begin
      issue(1'b1, ADDR_WIDTH'(t * 32 + 12), '1, rand_bits(WORD_WIDTH), -1);
    end

    // miss then hit on the other word of the same line
    issue(1'b0, 10'h046, '0, '0, MEM_LATENCY + 3);
    issue(1'b0, 10'h047, '0, '0, 2);
    issue(1'b0, 10'h0a9, '0, '0, MEM_LATENCY + 3);
    issue(1'b0, 10'h0a8, '0, '0, 2);
    issue(1'b0, 10'h31d, '0, '0, MEM_LATENCY + 3);
    issue(1'b0, 10'h31c, '0, '0, 2);

    // three tags on set 6, round-robin evicts the first one
    for (int t = 1; t <= 3; t++) begin
      issue(1'b0, ADDR_WIDTH'(t * 32 + 12), '0, '0, MEM_LATENCY + 3);
    end
    for (int t = 1; t <= 3; t++) begin
      issue(1'b0, ADDR_WIDTH'(t * 32 + 12), '0, '0, (t == 1) ? MEM_LATENCY + 3 : -1);
    end

    // random mix over a 128 word window, four tags per set
    for (int i = 0; i < NUM_RAND; i++) begin
      a  = ADDR_WIDTH'(64'h300 + rand_bits(7));
      we = 1'(rand_bits(1));
      be = BE_WIDTH'(rand_bits(BE_WIDTH));
      wd = rand_bits(WORD_WIDTH);
      issue(we, a, be, wd, -1);
    end

    // let the last response drain
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      fail_cnt++;
      $display("%0d load responses never arrived", exp_q.size());
    end

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // --------------------
  // watchdog
  // --------------------
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("run did not finish within %0d cycles", WDOG_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
